/* shake_loader.f */
logic/keccak_pkg.sv
logic/padding_generator.sv
logic/load_datapath.sv
logic/load_controller.sv
logic/block_issuer.sv
logic/shake_loader.sv
verif/tb_clock_gen.sv
verif/shake_loader_tb.sv

/* Bender.yml */
package:
  name: shake_loader

sources:
  - files:
      - logic/keccak_pkg.sv
      - logic/padding_generator.sv
      - logic/load_datapath.sv
      - logic/load_controller.sv
      - logic/block_issuer.sv
      - logic/shake_loader.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/shake_loader_tb.sv

/* verif/shake_loader_tb.sv */
`timescale 1ns/1ns

module shake_loader_tb
    import keccak_pkg::*;
();

    localparam int random_messages  = 5;
    localparam int max_random_bytes = 400;
    // Early bad writes, 100B, 300B, 168B, empty, 167B, 136B, then random messages
    localparam int transfer_budget  = 2 + 15 + 42 + 23 + 2 + 23 + 19
                                      + random_messages * (2 + max_random_bytes / 8);
    localparam int watchdog_ns      = transfer_budget * 40 * 10 + 5000;

    logic         clk;
    logic         rst_n;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [7:0]   paddr;
    logic [w-1:0] pwdata;
    logic [w-1:0] prdata;
    logic         pready;
    logic         pslverr;
    logic         block_valid;
    logic         block_ready;
    block_t       block;

    // Reference model state
    block_t       model_q[$];
    block_t       expected_block;
    int           pending_blocks;
    logic [7:0]   msg_bytes[$];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    shake_loader shake_loader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .block_valid (block_valid),
        .block_ready (block_ready),
        .block       (block)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    // Front of the model queue, seen by the block assertion
    task automatic refresh_expected();
        pending_blocks = model_q.size();
        if (pending_blocks != 0) begin
            expected_block = model_q[0];
        end else begin
            expected_block = '0;
        end
    endtask

    // Pads msg_bytes per SHAKE rules and queues one entry per rate block
    task automatic queue_expected_blocks(input op_mode_e mode, input logic [27:0] out_size,
                                         output int n_blocks);
        int         rate_bytes;
        int         total;
        logic [7:0] padded[];
        block_t     blk;
        rate_bytes = (mode == shake256_mode) ? rate_shake256 / 8 : rate_shake128 / 8;
        // Room for at least the domain byte
        total      = (msg_bytes.size() / rate_bytes + 1) * rate_bytes;
        padded     = new[total];
        for (int j = 0; j < total; j++) begin
            padded[j] = (j < msg_bytes.size()) ? msg_bytes[j] : 8'h00;
        end
        padded[msg_bytes.size()] = 8'h1f;
        padded[total-1]          = padded[total-1] | 8'h80;
        n_blocks = total / rate_bytes;
        for (int b = 0; b < n_blocks; b++) begin
            blk = '0;
            // Byte j of the block sits in bits 8j+7:8j
            for (int j = 0; j < rate_bytes; j++) begin
                blk.data[8*j +: 8] = padded[b*rate_bytes + j];
            end
            blk.last        = (b == n_blocks - 1);
            blk.mode        = mode;
            blk.output_size = {4'h0, out_size};
            model_q.push_back(blk);
        end
        refresh_expected();
    endtask

    // Setup phase, access phase, then wait for pready
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [63:0] wdata, output logic [63:0] rdata,
                                output logic err);
        logic done;
        done = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!done) begin
            @(posedge clk);
            if (pready) begin
                done = 1'b1;
                rdata = prdata;
                err   = pslverr;
                psel    <= 1'b0;
                penable <= 1'b0;
            end
        end
    endtask

    task automatic write_expect(input logic [7:0] addr, input logic [63:0] data,
                                input logic exp_err, input string what);
        logic [63:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_equal({what, " pslverr"}, err, exp_err);
    endtask

    task automatic read_status_expect(input logic [31:0] remaining, input int count,
                                      input logic busy, input string what);
        logic [63:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr_status, '0, rdata, err);
        check_equal({what, " pslverr"}, err, 1'b0);
        // Busy in bit 0, block count in 15:8, remaining bits in 63:32
        check_equal(what, rdata, {remaining, 16'h0000, 8'(count), 7'h00, busy});
    endtask

    // Whole message; probe_word >= 0 adds a status read and a bad header there
    task automatic send_message(input op_mode_e mode, input logic [27:0] out_size,
                                input int n_bytes, input int probe_word);
        int          n_words;
        int          n_blocks;
        int          depth;
        int          idx;
        logic [63:0] word;
        wait (pending_blocks == 0);
        msg_bytes = {};
        for (int i = 0; i < n_bytes; i++) begin
            msg_bytes.push_back(8'($urandom));
        end
        queue_expected_blocks(mode, out_size, n_blocks);
        depth   = (mode == shake256_mode) ? depth_shake256 : depth_shake128;
        n_words = (n_bytes + 7) / 8;
        write_expect(addr_header, {1'b0, mode, 1'b0, out_size, 32'(n_bytes * 8)}, 1'b0,
                     "header write");
        for (int i = 0; i < n_words; i++) begin
            if (i == probe_word) begin
                read_status_expect(32'(n_bytes * 8 - 64 * i), i / depth, 1'b1,
                                   "status mid-message");
                write_expect(addr_header, {1'b0, mode, 1'b0, ~out_size, 32'd64}, 1'b1,
                             "header during message");
            end
            // First byte in bits 63:56, tail past the message is junk
            for (int k = 0; k < 8; k++) begin
                idx = 8 * i + k;
                word[63-8*k -: 8] = (idx < n_bytes) ? msg_bytes[idx] : 8'($urandom);
            end
            write_expect(addr_data, word, 1'b0, "data write");
        end
        wait (pending_blocks == 0);
        read_status_expect(32'd0, n_blocks, 1'b0, "status after message");
    endtask

    // Low and high stretches of random length
    task automatic drive_block_ready();
        int low_cycles;
        int high_cycles;
        forever begin
            low_cycles  = $urandom_range(1, 8);
            high_cycles = $urandom_range(1, 3);
            repeat (low_cycles) begin
                @(posedge clk);
                block_ready <= 1'b0;
            end
            repeat (high_cycles) begin
                @(posedge clk);
                block_ready <= 1'b1;
            end
        end
    endtask

    // Model queue pops on each accepted block
    always @(posedge clk) begin
        if (rst_n && block_valid && block_ready && model_q.size() != 0) begin
            model_q.delete(0);
            refresh_expected();
        end
    end

    accept_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        (block_valid && block_ready) |-> (pending_blocks != 0 && block === expected_block))
        else abort_run($sformatf("FAILED at %0t ns: accepted block differs from model, %0d due",
                                 $time, pending_blocks));

    held_block_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (block_valid && !block_ready) |=> (block_valid && $stable(block)))
        else abort_run($sformatf("FAILED at %0t ns: held block changed or dropped valid",
                                 $time));

    data_stalled_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && pwrite && paddr == addr_data && block_valid) |-> !pready)
        else abort_run($sformatf("FAILED at %0t ns: data write accepted while block held",
                                 $time));

    status_read_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite && paddr == addr_status) |-> pready)
        else abort_run($sformatf("FAILED at %0t ns: status read stalled", $time));

    initial begin
        #(watchdog_ns);
        abort_run("Timeout: the run did not finish in the time allowed for its transfers");
    end

    initial begin
        int       rand_len;
        op_mode_e rand_mode;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        block_ready    = 1'b0;
        pending_blocks = 0;
        expected_block = '0;
        void'($urandom(95447));
        wait (rst_n === 1'b1);
        @(posedge clk);
        // Idle outputs before any transfer
        check_equal("block_valid after reset", block_valid, 1'b0);
        check_equal("pready after reset", pready, 1'b1);
        check_equal("pslverr after reset", pslverr, 1'b0);
        fork
            drive_block_ready();
        join_none
        // Rejected writes must not start a message
        write_expect(addr_data, 64'h0123456789abcdef, 1'b1, "data before header");
        write_expect(8'h18, 64'h0, 1'b1, "unmapped address");
        send_message(shake128_mode, 28'd256, 100, -1);
        send_message(shake256_mode, 28'h0abcdef, 300, 20);
        // Boundary and empty cases get a pad-only block
        send_message(shake128_mode, 28'd32, 168, -1);
        send_message(shake128_mode, 28'd16, 0, -1);
        // 0x1F and 0x80 in the same byte
        send_message(shake128_mode, 28'd512, 167, -1);
        send_message(shake256_mode, 28'd64, 136, -1);
        for (int i = 0; i < random_messages; i++) begin
            rand_len  = $urandom_range(0, max_random_bytes);
            rand_mode = ($urandom_range(0, 1) == 1) ? shake256_mode : shake128_mode;
            send_message(rand_mode, 28'($urandom), rand_len, -1);
        end
        repeat (20) @(posedge clk);
        if (pending_blocks != 0 || block_valid) begin
            abort_run("Blocks left over: model and DUT disagree on the number of blocks");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = ~clk;
        end
    end

    // Reset held over the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* logic/shake_loader.sv */
`timescale 1ns/1ns

module shake_loader
    import keccak_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [7:0]   paddr,
    input  logic [w-1:0] pwdata,
    output logic [w-1:0] prdata,
    output logic         pready,
    output logic         pslverr,
    output logic         block_valid,
    input  logic         block_ready,
    output block_t       block
);

    logic                     write_header;
    logic                     write_data;
    logic                     block_taken;
    load_ctrl_t               ctrl;
    load_status_t             status;
    load_state_e              state;
    logic [rate_shake128-1:0] block_data;
    header_t                  header;
    logic [31:0]              remaining_bits;

    // Sequencing of header, words, pad and hand-off
    load_controller controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_header (write_header),
        .write_data   (write_data),
        .block_taken  (block_taken),
        .status       (status),
        .ctrl         (ctrl),
        .state        (state)
    );

    // APB write data feeds the datapath directly
    load_datapath datapath_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .data_in        (pwdata),
        .status         (status),
        .block_data     (block_data),
        .header         (header),
        .remaining_bits (remaining_bits)
    );

    block_issuer issuer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .state          (state),
        .status         (status),
        .block_data     (block_data),
        .header         (header),
        .remaining_bits (remaining_bits),
        .write_header   (write_header),
        .write_data     (write_data),
        .block_taken    (block_taken),
        .block_valid    (block_valid),
        .block_ready    (block_ready),
        .block          (block)
    );

endmodule

/* logic/block_issuer.sv */
`timescale 1ns/1ns

module block_issuer
    import keccak_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [7:0]               paddr,
    input  logic [w-1:0]             pwdata,
    output logic [w-1:0]             prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  load_state_e              state,
    input  load_status_t             status,
    input  logic [rate_shake128-1:0] block_data,
    input  header_t                  header,
    input  logic [31:0]              remaining_bits,
    output logic                     write_header,
    output logic                     write_data,
    output logic                     block_taken,
    output logic                     block_valid,
    input  logic                     block_ready,
    output block_t                   block
);

    logic       access;
    logic       data_wr;
    logic       status_rd;
    logic       data_wait;
    logic [7:0] block_count;

    // APB access phase decode
    assign access    = psel & penable;
    assign data_wr   = access & pwrite & (paddr == addr_data);
    assign status_rd = access & ~pwrite & (paddr == addr_status);

    // Host stalls on data while a block is held
    assign data_wait = data_wr & (state == hold);
    assign pready    = ~data_wait;

    // Header only between messages, data only while words are due
    assign write_header = access & pwrite & (paddr == addr_header) & (state == idle);
    assign write_data   = data_wr & (state == load) & ~status.size_reached;

    // Anything completed that is neither a legal write nor a status read
    assign pslverr = access & pready & ~(write_header | write_data | status_rd);

    // Status word: busy, block count, remaining bits
    assign prdata = status_rd ?
                    {remaining_bits, 16'h0000, block_count, 7'h00, state != idle} : '0;

    assign block_valid = (state == hold);
    assign block_taken = block_valid & block_ready;

    // Contents are frozen in hold, so the block stays stable
    always_comb begin
        block.data        = block_data;
        block.last        = status.last_block;
        block.mode        = header.mode;
        block.output_size = {4'h0, header.output_size};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_count <= '0;
        end else if (write_header) begin
            block_count <= '0;
        end else if (block_taken) begin
            block_count <= block_count + 8'd1;
        end
    end

endmodule

/* logic/load_controller.sv */
`timescale 1ns/1ns

module load_controller
    import keccak_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         write_header,
    input  logic         write_data,
    input  logic         block_taken,
    input  load_status_t status,
    output load_ctrl_t   ctrl,
    output load_state_e  state
);

    load_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        ctrl       = '0;
        case (state)
            idle: begin
                // New message, buffer starts empty
                if (write_header) begin
                    ctrl.header_en   = 1'b1;
                    ctrl.block_clear = 1'b1;
                    next_state       = load;
                end
            end

            load: begin
                if (status.buffer_full) begin
                    next_state = hold;
                end else if (status.size_reached) begin
                    // Also covers a zero-length message
                    next_state = pad;
                end else if (write_data) begin
                    ctrl.word_en = 1'b1;
                    // Go straight to hold so valid rises next cycle
                    if (status.last_word_in_block) begin
                        next_state = hold;
                    end
                end
            end

            pad: begin
                if (status.buffer_full) begin
                    next_state = hold;
                end else begin
                    // One pad word per cycle until the block is full
                    ctrl.pad_en = 1'b1;
                    if (status.last_word_in_block) begin
                        next_state = hold;
                    end
                end
            end

            hold: begin
                if (block_taken) begin
                    ctrl.block_clear = 1'b1;
                    if (status.last_block) begin
                        next_state = idle;
                    end else if (status.size_reached) begin
                        // Message ended on a block boundary
                        next_state = pad;
                    end else begin
                        next_state = load;
                    end
                end
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

endmodule

/* logic/load_datapath.sv */
`timescale 1ns/1ns

module load_datapath
    import keccak_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  load_ctrl_t               ctrl,
    input  logic [w-1:0]             data_in,
    output load_status_t             status,
    output logic [rate_shake128-1:0] block_data,
    output header_t                  header,
    output logic [31:0]              remaining_bits
);

    logic [4:0]                        word_idx;
    logic [4:0]                        depth;
    logic                              word_write;
    logic                              pad_active;
    logic                              last_word_in_block;
    logic                              last_block;
    logic [w_byte_width-1:0]           remaining_valid_bytes;
    logic [w-1:0]                      padded_word;
    logic [w-1:0]                      swapped_word;
    logic [depth_shake128-1:0][w-1:0]  buffer;

    // Header fields taken apart from the APB word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            header <= '0;
        end else if (ctrl.header_en) begin
            header.mode        <= op_mode_e'(data_in[62:61]);
            header.output_size <= data_in[59:32];
            header.input_size  <= data_in[31:0];
        end
    end

    // Remaining input bits, one word per write, floor at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining_bits <= '0;
        end else if (ctrl.header_en) begin
            remaining_bits <= data_in[31:0];
        end else if (ctrl.word_en) begin
            if (remaining_bits > 32'd64) begin
                remaining_bits <= remaining_bits - 32'd64;
            end else begin
                remaining_bits <= '0;
            end
        end
    end

    // Rate block depth from the mode
    always_comb begin
        case (header.mode)
            shake256_mode: depth = 5'(depth_shake256);
            default:       depth = 5'(depth_shake128);
        endcase
    end

    assign word_write         = ctrl.word_en | ctrl.pad_en;
    assign last_word_in_block = (word_idx == depth - 5'd1);

    // Message ends inside this word, or already ended
    assign pad_active            = word_write & (remaining_bits < 32'd64);
    assign remaining_valid_bytes = remaining_bits[5:3];

    padding_generator padding_gen (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .data_in               (data_in),
        .remaining_valid_bytes (remaining_valid_bytes),
        .pad_active            (pad_active),
        .last_word_in_block    (last_word_in_block),
        .padding_reset         (ctrl.header_en),
        .last_block            (last_block),
        .data_out              (padded_word)
    );

    // Little-endian lanes, byte k of the word to bits 8k+7:8k
    always_comb begin
        for (int k = 0; k < w/8; k++) begin
            swapped_word[8*k +: 8] = padded_word[w-1-8*k -: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx <= '0;
        end else if (ctrl.block_clear) begin
            word_idx <= '0;
        end else if (word_write) begin
            word_idx <= word_idx + 5'd1;
        end
    end

    // Clearing keeps the unused SHAKE256 slots at zero
    always_ff @(posedge clk) begin
        if (ctrl.block_clear) begin
            buffer <= '0;
        end else if (word_write) begin
            buffer[word_idx] <= swapped_word;
        end
    end

    assign block_data = buffer;

    always_comb begin
        status.size_reached       = (remaining_bits == '0);
        status.buffer_full        = (word_idx == depth);
        status.last_word_in_block = last_word_in_block;
        status.last_block         = last_block;
    end

endmodule

/* logic/padding_generator.sv */
`timescale 1ns/1ns

module padding_generator
    import keccak_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [w-1:0]            data_in,
    input  logic [w_byte_width-1:0] remaining_valid_bytes,
    input  logic                    pad_active,
    input  logic                    last_word_in_block,
    input  logic                    padding_reset,
    output logic                    last_block,
    output logic [w-1:0]            data_out
);

    // Set once the 0x1F domain byte has gone into the buffer
    logic         pad_started;
    logic [5:0]   shift_bits;
    logic [w-1:0] keep_mask;
    logic [w-1:0] domain_word;

    // Byte count to bit shift
    assign shift_bits = {remaining_valid_bytes, 3'b000};

    // Leading bytes are message, first byte sits in bits 63:56
    assign keep_mask = ~({w{1'b1}} >> shift_bits);

    // Domain byte lands right after the last valid byte
    assign domain_word = {8'h1f, {(w-8){1'b0}}} >> shift_bits;

    always_comb begin
        // Full message word passes untouched
        data_out = data_in;
        if (pad_active) begin
            if (pad_started) begin
                // Pure pad word after the domain byte
                data_out = '0;
            end else begin
                data_out = (data_in & keep_mask) | domain_word;
            end
            // Final byte of the rate block, 0x9F when it meets 0x1F
            if (last_word_in_block) begin
                data_out[7:0] = data_out[7:0] | 8'h80;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pad_started <= 1'b0;
        end else if (padding_reset) begin
            pad_started <= 1'b0;
        end else if (pad_active) begin
            pad_started <= 1'b1;
        end
    end

    // Domain byte only ever sits in the final block
    assign last_block = pad_started;

endmodule

/* logic/keccak_pkg.sv */
package keccak_pkg;

    // Word and rate sizes fixed by FIPS 202
    localparam int w             = 64;
    localparam int w_byte_width  = 3;
    localparam int rate_shake128 = 1344;
    localparam int rate_shake256 = 1088;

    // Words per rate block
    localparam int depth_shake128 = rate_shake128 / w;
    localparam int depth_shake256 = rate_shake256 / w;

    // APB register map, byte addresses of 64-bit words
    localparam logic [7:0] addr_header = 8'd0;
    localparam logic [7:0] addr_data   = 8'd8;
    localparam logic [7:0] addr_status = 8'd16;

    // Unlisted mode codes fall back to SHAKE128
    typedef enum logic [1:0] {
        shake128_mode = 2'b00,
        shake256_mode = 2'b01
    } op_mode_e;

    typedef enum logic [1:0] {
        idle = 2'b00,
        load = 2'b01,
        pad  = 2'b10,
        hold = 2'b11
    } load_state_e;

    // Header word fields, bit 60 of the APB word is unused
    typedef struct packed {
        op_mode_e    mode;
        logic [27:0] output_size;
        logic [31:0] input_size;
    } header_t;

    // Controller strobes into the datapath
    typedef struct packed {
        logic header_en;
        logic word_en;
        logic pad_en;
        logic block_clear;
    } load_ctrl_t;

    // Datapath flags back to the controller
    typedef struct packed {
        logic size_reached;
        logic buffer_full;
        logic last_word_in_block;
        logic last_block;
    } load_status_t;

    // Downstream block, SHAKE256 leaves the top 256 bits zero
    typedef struct packed {
        logic [rate_shake128-1:0] data;
        logic                     last;
        op_mode_e                 mode;
        logic [31:0]              output_size;
    } block_t;

endpackage
